// File: hdl/regread_pkg.sv
package regread_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int UOP_W  = 4;

    // Operation classes handed to execute
    localparam logic [UOP_W-1:0] UOP_NOP  = 4'd0;
    localparam logic [UOP_W-1:0] UOP_ADD  = 4'd1;
    localparam logic [UOP_W-1:0] UOP_SUB  = 4'd2;
    localparam logic [UOP_W-1:0] UOP_AND  = 4'd3;
    localparam logic [UOP_W-1:0] UOP_OR   = 4'd4;
    localparam logic [UOP_W-1:0] UOP_ADDI = 4'd5;
    localparam logic [UOP_W-1:0] UOP_ANDI = 4'd6;
    localparam logic [UOP_W-1:0] UOP_ORI  = 4'd7;

    // 3R format, inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;

    typedef union packed {
        struct packed {
            logic [16:0]       opcode;
            logic [REG_AW-1:0] rk;
            logic [REG_AW-1:0] rj;
            logic [REG_AW-1:0] rd;
        } r3;
        struct packed {
            logic [9:0]        opcode;
            logic [11:0]       imm12;
            logic [REG_AW-1:0] rj;
            logic [REG_AW-1:0] rd;
        } ri12;
    } inst_word_u;

endpackage

// File: hdl/regfile.sv
module regfile import regread_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              we0,
    input  logic              we1,
    input  logic              we2,
    input  logic [REG_AW-1:0] waddr0,
    input  logic [REG_AW-1:0] waddr1,
    input  logic [REG_AW-1:0] waddr2,
    input  logic [XLEN-1:0]   wdata0,
    input  logic [XLEN-1:0]   wdata1,
    input  logic [XLEN-1:0]   wdata2,
    input  logic [REG_AW-1:0] raddr0,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    input  logic [REG_AW-1:0] raddr3,
    output logic [XLEN-1:0]   rdata0,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2,
    output logic [XLEN-1:0]   rdata3
);

    logic [XLEN-1:0] regs [2**REG_AW];

    // Write-first read, port 2 checked last so it wins
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        logic [XLEN-1:0] val;
        val = regs[addr];
        if (we0 && waddr0 == addr && waddr0 != '0) val = wdata0;
        if (we1 && waddr1 == addr && waddr1 != '0) val = wdata1;
        if (we2 && waddr2 == addr && waddr2 != '0) val = wdata2;
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_AW; i++)
                regs[i] <= '0;
        end else begin
            if (we0 && waddr0 != '0) regs[waddr0] <= wdata0;
            if (we1 && waddr1 != '0) regs[waddr1] <= wdata1;
            if (we2 && waddr2 != '0) regs[waddr2] <= wdata2; // last one wins
        end
    end

    assign rdata0 = read_port(raddr0);
    assign rdata1 = read_port(raddr1);
    assign rdata2 = read_port(raddr2);
    assign rdata3 = read_port(raddr3);

    // r0 must survive any write-back traffic
    a_r0_zero: assert property (@(posedge clk) disable iff (rst)
        (raddr0 == '0 |-> rdata0 == '0) and (raddr1 == '0 |-> rdata1 == '0) and
        (raddr2 == '0 |-> rdata2 == '0) and (raddr3 == '0 |-> rdata3 == '0))
        else $error("regfile: r0 read back non-zero");

endmodule

// File: hdl/inst_field_decode.sv
module inst_field_decode import regread_pkg::*; (
    input  logic [XLEN-1:0]   inst,
    output logic [REG_AW-1:0] rj,
    output logic [REG_AW-1:0] rk,
    output logic [REG_AW-1:0] rd,
    output logic [XLEN-1:0]   imm,
    output logic [UOP_W-1:0]  uop,
    output logic              rd_we
);

    inst_word_u w;
    logic       is_r3;

    assign w = inst;

    always_comb begin
        rj    = '0;
        rk    = '0;
        rd    = '0;
        imm   = '0;
        uop   = UOP_NOP;
        is_r3 = 1'b1;
        case (w.r3.opcode)
            OPC_ADD_W: uop = UOP_ADD;
            OPC_SUB_W: uop = UOP_SUB;
            OPC_AND:   uop = UOP_AND;
            OPC_OR:    uop = UOP_OR;
            default: begin
                is_r3 = 1'b0;
                case (w.ri12.opcode)
                    OPC_ADDI_W: begin
                        uop = UOP_ADDI;
                        imm = {{(XLEN-12){w.ri12.imm12[11]}}, w.ri12.imm12};
                    end
                    OPC_ANDI: begin
                        uop = UOP_ANDI;
                        imm = {{(XLEN-12){1'b0}}, w.ri12.imm12}; // Logical ops zero-extend
                    end
                    OPC_ORI: begin
                        uop = UOP_ORI;
                        imm = {{(XLEN-12){1'b0}}, w.ri12.imm12};
                    end
                    default: ;
                endcase
            end
        endcase

        if (is_r3) begin
            rj = w.r3.rj;
            rk = w.r3.rk;
            rd = w.r3.rd;
        end else if (uop != UOP_NOP) begin
            rj = w.ri12.rj;
            rd = w.ri12.rd;
        end
    end

    assign rd_we = (uop != UOP_NOP) && (rd != '0);

endmodule

// File: hdl/forward_unit.sv
module forward_unit import regread_pkg::*; (
    input  logic [REG_AW-1:0] src_j0,
    input  logic [REG_AW-1:0] src_k0,
    input  logic [REG_AW-1:0] src_j1,
    input  logic [REG_AW-1:0] src_k1,
    input  logic              fwd_we0,
    input  logic              fwd_we1,
    input  logic [REG_AW-1:0] fwd_rd0,
    input  logic [REG_AW-1:0] fwd_rd1,
    input  logic [XLEN-1:0]   fwd_data0,
    input  logic [XLEN-1:0]   fwd_data1,
    output logic              hit_j0,
    output logic              hit_k0,
    output logic              hit_j1,
    output logic              hit_k1,
    output logic [XLEN-1:0]   data_j0,
    output logic [XLEN-1:0]   data_k0,
    output logic [XLEN-1:0]   data_j1,
    output logic [XLEN-1:0]   data_k1
);

    function automatic logic lane_hit(input logic              we,
                                      input logic [REG_AW-1:0] dst,
                                      input logic [REG_AW-1:0] src);
        return we && dst != '0 && dst == src;
    endfunction

    // Younger lane 1 takes priority
    function automatic logic [XLEN-1:0] pick(input logic [REG_AW-1:0] src);
        if (lane_hit(fwd_we1, fwd_rd1, src))
            return fwd_data1;
        if (lane_hit(fwd_we0, fwd_rd0, src))
            return fwd_data0;
        return '0;
    endfunction

    assign hit_j0 = lane_hit(fwd_we0, fwd_rd0, src_j0) || lane_hit(fwd_we1, fwd_rd1, src_j0);
    assign hit_k0 = lane_hit(fwd_we0, fwd_rd0, src_k0) || lane_hit(fwd_we1, fwd_rd1, src_k0);
    assign hit_j1 = lane_hit(fwd_we0, fwd_rd0, src_j1) || lane_hit(fwd_we1, fwd_rd1, src_j1);
    assign hit_k1 = lane_hit(fwd_we0, fwd_rd0, src_k1) || lane_hit(fwd_we1, fwd_rd1, src_k1);

    assign data_j0 = pick(src_j0);
    assign data_k0 = pick(src_k0);
    assign data_j1 = pick(src_j1);
    assign data_k1 = pick(src_k1);

endmodule

// File: hdl/regread_stage.sv
module regread_stage import regread_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              id_readygo,
    input  logic              ex_allowin,
    input  logic              forward_stall,
    input  logic              hold,
    output logic              in_allowin,
    output logic              ex_readygo,
    input  logic [XLEN-1:0]   pc0,
    input  logic [XLEN-1:0]   pc1,
    input  logic [XLEN-1:0]   inst0,
    input  logic [XLEN-1:0]   inst1,
    input  logic [UOP_W-1:0]  uop0,
    input  logic [UOP_W-1:0]  uop1,
    input  logic [XLEN-1:0]   imm0,
    input  logic [XLEN-1:0]   imm1,
    input  logic [REG_AW-1:0] rj0,
    input  logic [REG_AW-1:0] rj1,
    input  logic [REG_AW-1:0] rk0,
    input  logic [REG_AW-1:0] rk1,
    input  logic [REG_AW-1:0] rd0,
    input  logic [REG_AW-1:0] rd1,
    input  logic              rd_we0,
    input  logic              rd_we1,
    input  logic [XLEN-1:0]   rj0_data,
    input  logic [XLEN-1:0]   rk0_data,
    input  logic [XLEN-1:0]   rj1_data,
    input  logic [XLEN-1:0]   rk1_data,
    input  logic              hit_j0,
    input  logic              hit_k0,
    input  logic              hit_j1,
    input  logic              hit_k1,
    input  logic [XLEN-1:0]   data_j0,
    input  logic [XLEN-1:0]   data_k0,
    input  logic [XLEN-1:0]   data_j1,
    input  logic [XLEN-1:0]   data_k1,
    output logic [XLEN-1:0]   ex_pc0,
    output logic [XLEN-1:0]   ex_pc1,
    output logic [XLEN-1:0]   ex_inst0,
    output logic [XLEN-1:0]   ex_inst1,
    output logic [UOP_W-1:0]  ex_uop0,
    output logic [UOP_W-1:0]  ex_uop1,
    output logic [XLEN-1:0]   ex_imm0,
    output logic [XLEN-1:0]   ex_imm1,
    output logic [REG_AW-1:0] ex_rj0,
    output logic [REG_AW-1:0] ex_rj1,
    output logic [REG_AW-1:0] ex_rk0,
    output logic [REG_AW-1:0] ex_rk1,
    output logic [REG_AW-1:0] ex_rd0,
    output logic [REG_AW-1:0] ex_rd1,
    output logic              ex_we0,
    output logic              ex_we1,
    output logic [XLEN-1:0]   ex_rj0_data,
    output logic [XLEN-1:0]   ex_rk0_data,
    output logic [XLEN-1:0]   ex_rj1_data,
    output logic [XLEN-1:0]   ex_rk1_data
);

    logic bubble;

    assign in_allowin = ex_allowin;
    assign ex_readygo = !forward_stall;

    // Nothing offered while execute drains
    assign bubble = !id_readygo && ex_allowin && !forward_stall;

    always_ff @(posedge clk) begin
        if (rst || flush || bubble) begin
            {ex_pc0, ex_pc1, ex_inst0, ex_inst1} <= '0;
            {ex_uop0, ex_uop1, ex_imm0, ex_imm1} <= '0;
            {ex_rj0, ex_rj1, ex_rk0, ex_rk1, ex_rd0, ex_rd1} <= '0;
            {ex_we0, ex_we1} <= '0;
            {ex_rj0_data, ex_rk0_data, ex_rj1_data, ex_rk1_data} <= '0;
        end else if (id_readygo && ex_allowin) begin
            ex_pc0      <= pc0;
            ex_pc1      <= pc1;
            ex_inst0    <= inst0;
            ex_inst1    <= inst1;
            ex_uop0     <= uop0;
            ex_uop1     <= uop1;
            ex_imm0     <= imm0;
            ex_imm1     <= imm1;
            ex_rj0      <= rj0;
            ex_rj1      <= rj1;
            ex_rk0      <= rk0;
            ex_rk1      <= rk1;
            ex_rd0      <= rd0;
            ex_rd1      <= rd1;
            ex_we0      <= rd_we0;
            ex_we1      <= rd_we1;
            ex_rj0_data <= rj0_data;
            ex_rk0_data <= rk0_data;
            ex_rj1_data <= rj1_data;
            ex_rk1_data <= rk1_data;
        end else if (hold) begin
            // Refresh stale operands from execute
            if (hit_j0) ex_rj0_data <= data_j0;
            if (hit_k0) ex_rk0_data <= data_k0;
            if (hit_j1) ex_rj1_data <= data_j1;
            if (hit_k1) ex_rk1_data <= data_k1;
        end
    end

    // A stalled pair stays put until decode offers the next one
    a_stall_keeps_pair: assert property (@(posedge clk) disable iff (rst)
        !ex_readygo && !id_readygo && !flush |=> $stable(ex_pc0) && $stable(ex_pc1))
        else $error("regread_stage: stalled pair dropped by a bubble");

    a_flush_kills: assert property (@(posedge clk) flush |=> !ex_we0 && !ex_we1)
        else $error("regread_stage: write enable survived a flush");

endmodule

// File: hdl/regread_top.sv
module regread_top import regread_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              id_readygo,
    input  logic [XLEN-1:0]   pc0,
    input  logic [XLEN-1:0]   pc1,
    input  logic [XLEN-1:0]   inst0,
    input  logic [XLEN-1:0]   inst1,
    output logic              in_allowin,
    input  logic              ex_allowin,
    input  logic              forward_stall,
    input  logic              hold,
    output logic              ex_readygo,
    input  logic              wb_we0,
    input  logic              wb_we1,
    input  logic              wb_we2,
    input  logic [REG_AW-1:0] wb_rd0,
    input  logic [REG_AW-1:0] wb_rd1,
    input  logic [REG_AW-1:0] wb_rd2,
    input  logic [XLEN-1:0]   wb_data0,
    input  logic [XLEN-1:0]   wb_data1,
    input  logic [XLEN-1:0]   wb_data2,
    input  logic              fwd_we0,
    input  logic              fwd_we1,
    input  logic [REG_AW-1:0] fwd_rd0,
    input  logic [REG_AW-1:0] fwd_rd1,
    input  logic [XLEN-1:0]   fwd_data0,
    input  logic [XLEN-1:0]   fwd_data1,
    output logic [XLEN-1:0]   ex_pc0,
    output logic [XLEN-1:0]   ex_pc1,
    output logic [XLEN-1:0]   ex_inst0,
    output logic [XLEN-1:0]   ex_inst1,
    output logic [UOP_W-1:0]  ex_uop0,
    output logic [UOP_W-1:0]  ex_uop1,
    output logic [XLEN-1:0]   ex_imm0,
    output logic [XLEN-1:0]   ex_imm1,
    output logic [REG_AW-1:0] ex_rj0,
    output logic [REG_AW-1:0] ex_rj1,
    output logic [REG_AW-1:0] ex_rk0,
    output logic [REG_AW-1:0] ex_rk1,
    output logic [REG_AW-1:0] ex_rd0,
    output logic [REG_AW-1:0] ex_rd1,
    output logic              ex_we0,
    output logic              ex_we1,
    output logic [XLEN-1:0]   ex_rj0_data,
    output logic [XLEN-1:0]   ex_rk0_data,
    output logic [XLEN-1:0]   ex_rj1_data,
    output logic [XLEN-1:0]   ex_rk1_data
);

    logic [REG_AW-1:0] rj0, rk0, rd0, rj1, rk1, rd1;
    logic [XLEN-1:0]   imm0, imm1;
    logic [UOP_W-1:0]  uop0, uop1;
    logic              rd_we0, rd_we1;
    logic [XLEN-1:0]   rj0_data, rk0_data, rj1_data, rk1_data;
    logic              hit_j0, hit_k0, hit_j1, hit_k1;
    logic [XLEN-1:0]   data_j0, data_k0, data_j1, data_k1;

    inst_field_decode dec0 (
        .inst  (inst0),
        .rj    (rj0),
        .rk    (rk0),
        .rd    (rd0),
        .imm   (imm0),
        .uop   (uop0),
        .rd_we (rd_we0)
    );

    inst_field_decode dec1 (
        .inst  (inst1),
        .rj    (rj1),
        .rk    (rk1),
        .rd    (rd1),
        .imm   (imm1),
        .uop   (uop1),
        .rd_we (rd_we1)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .we0    (wb_we0),
        .we1    (wb_we1),
        .we2    (wb_we2),
        .waddr0 (wb_rd0),
        .waddr1 (wb_rd1),
        .waddr2 (wb_rd2),
        .wdata0 (wb_data0),
        .wdata1 (wb_data1),
        .wdata2 (wb_data2),
        .raddr0 (rj0),
        .raddr1 (rk0),
        .raddr2 (rj1),
        .raddr3 (rk1),
        .rdata0 (rj0_data),
        .rdata1 (rk0_data),
        .rdata2 (rj1_data),
        .rdata3 (rk1_data)
    );

    // Held sources come straight from the stage register
    forward_unit u_forward (
        .src_j0 (ex_rj0),
        .src_k0 (ex_rk0),
        .src_j1 (ex_rj1),
        .src_k1 (ex_rk1),
        .*
    );

    regread_stage u_stage (.*);

endmodule

// File: verification/tb_regread.sv
module tb_regread import regread_pkg::*; ();

    localparam int RESET_CYC   = 4;
    localparam int CAPTURE_CYC = 60;
    localparam int FLUSH_CYC   = 12;
    localparam int BP_CYC      = 40;
    localparam int FWD_CYC     = 45;
    localparam int TOTAL_CYC   = RESET_CYC + CAPTURE_CYC + FLUSH_CYC + BP_CYC + FWD_CYC;
    localparam int WATCHDOG_TIME = (TOTAL_CYC + 5 * 3 + 20) * 100; // 3 drain cycles per test

    logic clk, rst, flush, id_readygo, in_allowin, ex_allowin, forward_stall, hold, ex_readygo;
    logic [XLEN-1:0]   pc0, pc1, inst0, inst1;
    logic              wb_we0, wb_we1, wb_we2, fwd_we0, fwd_we1;
    logic [REG_AW-1:0] wb_rd0, wb_rd1, wb_rd2, fwd_rd0, fwd_rd1;
    logic [XLEN-1:0]   wb_data0, wb_data1, wb_data2, fwd_data0, fwd_data1;
    logic [XLEN-1:0]   ex_pc0, ex_pc1, ex_inst0, ex_inst1, ex_imm0, ex_imm1;
    logic [UOP_W-1:0]  ex_uop0, ex_uop1;
    logic [REG_AW-1:0] ex_rj0, ex_rj1, ex_rk0, ex_rk1, ex_rd0, ex_rd1;
    logic              ex_we0, ex_we1;
    logic [XLEN-1:0]   ex_rj0_data, ex_rk0_data, ex_rj1_data, ex_rk1_data;

    // Expected decode of the pair currently offered, indexed by lane
    logic [1:0][UOP_W-1:0]  nxt_uop;
    logic [1:0][XLEN-1:0]   nxt_imm;
    logic [1:0][REG_AW-1:0] nxt_rj, nxt_rk, nxt_rd;
    logic [1:0]             nxt_we;

    // Expected stage contents
    logic [1:0][XLEN-1:0]   exp_pc, exp_inst, exp_imm, exp_jd, exp_kd;
    logic [1:0][UOP_W-1:0]  exp_uop;
    logic [1:0][REG_AW-1:0] exp_rj, exp_rk, exp_rd;
    logic [1:0]             exp_we;
    logic [XLEN-1:0]        shadow [2**REG_AW];
    logic                   model_valid = 1'b0;

    int errors = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;

    regread_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

    // Register read as the write-back rule defines it, higher port last
    function automatic logic [XLEN-1:0] expect_read(input logic [REG_AW-1:0] a);
        logic [XLEN-1:0] v;
        v = shadow[a];
        if (wb_we0 && wb_rd0 == a) v = wb_data0;
        if (wb_we1 && wb_rd1 == a) v = wb_data1;
        if (wb_we2 && wb_rd2 == a) v = wb_data2;
        if (a == '0) v = '0;
        return v;
    endfunction

    function automatic logic [XLEN-1:0] held_operand(input logic [REG_AW-1:0] src,
                                                     input logic [XLEN-1:0]   cur);
        if (fwd_we1 && fwd_rd1 != '0 && fwd_rd1 == src) return fwd_data1; // younger lane
        if (fwd_we0 && fwd_rd0 != '0 && fwd_rd0 == src) return fwd_data0;
        return cur;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            model_valid <= 1'b1;
            for (int i = 0; i < 2**REG_AW; i++)
                shadow[i] <= '0;
        end else begin
            if (wb_we0 && wb_rd0 != '0) shadow[wb_rd0] <= wb_data0;
            if (wb_we1 && wb_rd1 != '0) shadow[wb_rd1] <= wb_data1;
            if (wb_we2 && wb_rd2 != '0) shadow[wb_rd2] <= wb_data2;
        end

        if (rst || flush || (!id_readygo && ex_allowin && !forward_stall)) begin
            {exp_pc, exp_inst, exp_imm, exp_jd, exp_kd} <= '0;
            {exp_uop, exp_rj, exp_rk, exp_rd, exp_we} <= '0;
        end else if (id_readygo && ex_allowin) begin
            exp_pc   <= {pc1, pc0};
            exp_inst <= {inst1, inst0};
            exp_uop  <= nxt_uop;
            exp_imm  <= nxt_imm;
            exp_rj   <= nxt_rj;
            exp_rk   <= nxt_rk;
            exp_rd   <= nxt_rd;
            exp_we   <= nxt_we;
            exp_jd   <= {expect_read(nxt_rj[1]), expect_read(nxt_rj[0])};
            exp_kd   <= {expect_read(nxt_rk[1]), expect_read(nxt_rk[0])};
        end else if (hold) begin
            exp_jd <= {held_operand(exp_rj[1], exp_jd[1]), held_operand(exp_rj[0], exp_jd[0])};
            exp_kd <= {held_operand(exp_rk[1], exp_kd[1]), held_operand(exp_rk[0], exp_kd[0])};
        end
    end

    task automatic log_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    a_fields: assert property (@(posedge clk) model_valid |->
        {ex_pc1, ex_pc0} == exp_pc && {ex_inst1, ex_inst0} == exp_inst &&
        {ex_uop1, ex_uop0} == exp_uop && {ex_imm1, ex_imm0} == exp_imm &&
        {ex_rj1, ex_rj0} == exp_rj && {ex_rk1, ex_rk0} == exp_rk &&
        {ex_rd1, ex_rd0} == exp_rd && {ex_we1, ex_we0} == exp_we)
        else log_mismatch("stage fields differ from expected decode");

    a_operands: assert property (@(posedge clk) model_valid |->
        {ex_rj1_data, ex_rj0_data} == exp_jd && {ex_rk1_data, ex_rk0_data} == exp_kd)
        else log_mismatch("operand data differs from shadow register file");

    a_allowin: assert property (@(posedge clk) in_allowin == ex_allowin)
        else log_mismatch("in_allowin does not follow ex_allowin");

    a_readygo: assert property (@(posedge clk) ex_readygo == !forward_stall)
        else log_mismatch("ex_readygo is not the inverse of forward_stall");

    a_reset_state: assert property (@(posedge clk) rst |=>
        !ex_we0 && !ex_we1 && ex_uop0 == UOP_NOP && ex_uop1 == UOP_NOP &&
        ex_rj0_data == '0 && ex_rk0_data == '0 && ex_rj1_data == '0 && ex_rk1_data == '0)
        else log_mismatch("outputs not cleared by reset");

    a_flush_clears: assert property (@(posedge clk) !rst && flush |=>
        ex_pc0 == '0 && ex_pc1 == '0 && !ex_we0 && !ex_we1 && ex_rj0_data == '0)
        else log_mismatch("flush did not clear the stage");

    a_bubble_clears: assert property (@(posedge clk)
        !rst && !id_readygo && ex_allowin && !forward_stall |=>
        ex_uop0 == UOP_NOP && ex_uop1 == UOP_NOP && !ex_we0 && !ex_we1 && ex_inst0 == '0)
        else log_mismatch("no bubble inserted while decode was empty");

    a_stall_holds: assert property (@(posedge clk)
        !rst && !flush && !id_readygo && forward_stall && !hold |=>
        ex_pc0 == $past(ex_pc0) && ex_inst1 == $past(ex_inst1) &&
        ex_rk0_data == $past(ex_rk0_data))
        else log_mismatch("stage changed under forward_stall");

    a_backpressure_holds: assert property (@(posedge clk)
        !rst && !flush && !ex_allowin && !hold |=>
        ex_pc1 == $past(ex_pc1) && ex_uop0 == $past(ex_uop0) &&
        ex_rj1_data == $past(ex_rj1_data))
        else log_mismatch("stage changed while execute refused it");

    a_lane1_wins: assert property (@(posedge clk)
        !rst && !flush && !ex_allowin && hold && fwd_we1 && fwd_rd1 != '0 && fwd_rd1 == ex_rj0
        |=> ex_rj0_data == $past(fwd_data1))
        else log_mismatch("held rj0 not replaced by lane 1 producer");

    function automatic logic [REG_AW-1:0] pick_reg();
        return REG_AW'($urandom_range(0, 7)); // Narrow range so hazards collide
    endfunction

    // Kinds 0..3 are 3R, 4..6 are 2RI12, anything else is an unknown word
    task automatic set_lane(input logic lane, input int kind, input logic [REG_AW-1:0] rd,
                            input logic [REG_AW-1:0] rj, input logic [REG_AW-1:0] rk,
                            input logic [11:0] imm12);
        inst_word_u       w;
        logic [UOP_W-1:0] u;
        logic [XLEN-1:0]  im;
        logic [16:0]      op3;
        logic [9:0]       op12;
        op3 = '0;
        op12 = '0;
        im = '0;
        case (kind)
            0: begin u = UOP_ADD; op3 = OPC_ADD_W; end
            1: begin u = UOP_SUB; op3 = OPC_SUB_W; end
            2: begin u = UOP_AND; op3 = OPC_AND; end
            3: begin u = UOP_OR; op3 = OPC_OR; end
            4: begin u = UOP_ADDI; op12 = OPC_ADDI_W; im = {{20{imm12[11]}}, imm12}; end
            5: begin u = UOP_ANDI; op12 = OPC_ANDI; im = {20'd0, imm12}; end
            6: begin u = UOP_ORI; op12 = OPC_ORI; im = {20'd0, imm12}; end
            default: u = UOP_NOP;
        endcase
        if (kind < 4) begin
            w.r3.opcode = op3;
            w.r3.rk = rk;
            w.r3.rj = rj;
            w.r3.rd = rd;
        end else if (u != UOP_NOP) begin
            w.ri12.opcode = op12;
            w.ri12.imm12 = imm12;
            w.ri12.rj = rj;
            w.ri12.rd = rd;
        end else begin
            w = {10'h3ff, 22'($urandom)};
        end
        if (lane) inst1 <= w;
        else inst0 <= w;
        nxt_uop[lane] <= u;
        nxt_imm[lane] <= im;
        nxt_rj[lane]  <= (u == UOP_NOP) ? '0 : rj;
        nxt_rk[lane]  <= (kind < 4) ? rk : '0;
        nxt_rd[lane]  <= (u == UOP_NOP) ? '0 : rd;
        nxt_we[lane]  <= u != UOP_NOP && rd != '0;
    endtask

    task automatic random_pair();
        logic [XLEN-1:0] pc;
        pc = $urandom & 32'hffff_fff8;
        pc0 <= pc;
        pc1 <= pc + 32'd4;
        set_lane(1'b0, int'($urandom_range(0, 7)), pick_reg(), pick_reg(), pick_reg(),
                 12'($urandom));
        set_lane(1'b1, int'($urandom_range(0, 7)), pick_reg(), pick_reg(), pick_reg(),
                 12'($urandom));
    endtask

    task automatic random_wb();
        wb_we0   <= 1'($urandom_range(0, 1));
        wb_we1   <= 1'($urandom_range(0, 1));
        wb_we2   <= 1'($urandom_range(0, 1));
        wb_rd0   <= pick_reg();
        wb_rd1   <= pick_reg();
        wb_rd2   <= pick_reg();
        wb_data0 <= $urandom;
        wb_data1 <= $urandom;
        wb_data2 <= $urandom;
    endtask

    task automatic set_control(input logic fl, input logic go, input logic allow,
                               input logic stall, input logic hd);
        flush         <= fl;
        id_readygo    <= go;
        ex_allowin    <= allow;
        forward_stall <= stall;
        hold          <= hd;
    endtask

    task automatic set_fwd(input logic we0, input logic [REG_AW-1:0] rd0,
                           input logic we1, input logic [REG_AW-1:0] rd1);
        fwd_we0   <= we0;
        fwd_rd0   <= rd0;
        fwd_data0 <= $urandom;
        fwd_we1   <= we1;
        fwd_rd1   <= rd1;
        fwd_data1 <= $urandom;
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);
        @(negedge clk);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        void'($urandom(32'hacd3_6693));
        rst = 1'b1;
        {flush, id_readygo, ex_allowin, forward_stall, hold} = 5'b00100;
        {pc0, pc1, inst0, inst1} = '0;
        {wb_we0, wb_we1, wb_we2, wb_rd0, wb_rd1, wb_rd2} = '0;
        {wb_data0, wb_data1, wb_data2} = '0;
        {fwd_we0, fwd_we1, fwd_rd0, fwd_rd1, fwd_data0, fwd_data1} = '0;
        {nxt_uop, nxt_imm, nxt_rj, nxt_rk, nxt_rd, nxt_we} = '0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (RESET_CYC - 2) @(posedge clk);
        end_test("reset_state");

        repeat (CAPTURE_CYC) begin
            @(posedge clk);
            set_control(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
            random_pair();
            random_wb();
        end
        end_test("capture");

        // Flush, bubble, stall-hold and capture under stall, each after a fresh pair
        for (int sc = 0; sc < FLUSH_CYC / 3; sc++) begin
            @(posedge clk);
            set_control(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
            random_pair();
            @(posedge clk);
            case (sc)
                0: set_control(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
                1: set_control(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                2: set_control(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
                default: set_control(1'b0, 1'b1, 1'b1, 1'b1, 1'b0);
            endcase
            @(posedge clk);
            set_control(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        end
        end_test("flush_bubble");

        repeat (BP_CYC) begin
            @(posedge clk);
            set_control(1'b0, $urandom_range(0, 3) != 0, 1'($urandom_range(0, 1)),
                        $urandom_range(0, 3) == 0, 1'b0);
            random_pair();
            random_wb();
        end
        end_test("backpressure");

        @(posedge clk);
        set_control(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
        set_lane(1'b0, 0, 5'd1, 5'd3, 5'd4, 12'd0);
        set_lane(1'b1, 3, 5'd2, 5'd5, 5'd3, 12'd0);
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        @(posedge clk);
        set_control(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        set_fwd(1'b1, 5'd3, 1'b0, 5'd0);     // rj0 and rk1 refreshed
        @(posedge clk);
        set_fwd(1'b1, 5'd3, 1'b1, 5'd3);
        @(posedge clk);
        set_fwd(1'b1, 5'd0, 1'b0, 5'd4);     // Neither may touch an operand
        @(posedge clk);
        set_fwd(1'b0, 5'd0, 1'b0, 5'd0);
        repeat (FWD_CYC - 5) begin
            @(posedge clk);
            if ($urandom_range(0, 3) == 0) begin
                set_control(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
                random_pair();
            end else begin
                set_control(1'b0, 1'($urandom_range(0, 1)), 1'b0,
                            1'($urandom_range(0, 1)), 1'b1);
            end
            set_fwd(1'($urandom_range(0, 1)), pick_reg(), 1'($urandom_range(0, 1)), pick_reg());
            random_wb();
        end
        end_test("forward_hold");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: src.f
hdl/regread_pkg.sv
hdl/regfile.sv
hdl/inst_field_decode.sv
hdl/forward_unit.sv
hdl/regread_stage.sv
hdl/regread_top.sv
verification/tb_regread.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_regread
RTL_TOP    ?= regread_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   := Simulation completed successfully
FAIL_MSG   := Simulation failed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
